//--- mc_pi_params.svh
// **********************************************************
// Raster timing, board geometry, LFSR seed and datapath
// width macros for the Monte Carlo pi board
// **********************************************************
`ifndef MC_PI_PARAMS_SVH
`define MC_PI_PARAMS_SVH

// 640x480 raster, counts in pixel clocks
`define MC_H_ACTIVE 640
`define MC_H_FRONT 16
`define MC_H_SYNC 96
`define MC_H_TOTAL 800

// Vertical counts in lines
`define MC_V_ACTIVE 480
`define MC_V_FRONT 10
`define MC_V_SYNC 2
`define MC_V_TOTAL 525

// Board geometry, radius doubles as half side of the square
`define MC_CENTER_X 320
`define MC_CENTER_Y 240
`define MC_RADIUS 160
`define MC_MARK_HALF 10

`define MC_COORD_W 10
`define MC_LFSR_W 20
`define MC_LFSR_SEED 20'h80A01
`define MC_COUNT_W 32

`endif

//--- mc_pi_pkg.sv
// **********************************************************
// Shared types, square bounds and geometry helper functions
// **********************************************************
`default_nettype none
`include "mc_pi_params.svh"

package mc_pi_pkg;

  typedef logic [`MC_COORD_W-1:0] coord_t;
  typedef logic [2*`MC_COORD_W:0] dist_sq_t;  // Holds dx^2 + dy^2 anywhere on the raster

  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   active;
  } pixel_pos_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  typedef struct packed {
    point_t pt;
    logic   in_circle;
    logic   in_square;
  } hit_t;

  typedef struct packed {
    logic [`MC_COUNT_W-1:0] circle_hits;
    logic [`MC_COUNT_W-1:0] square_hits;
  } tally_t;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic [1:0] red;
    logic [1:0] green;
    logic [1:0] blue;
  } vga_out_t;

  // Square edges, the interior lies strictly between them
  localparam int SQ_X_LO = `MC_CENTER_X - `MC_RADIUS;
  localparam int SQ_X_HI = `MC_CENTER_X + `MC_RADIUS;
  localparam int SQ_Y_LO = `MC_CENTER_Y - `MC_RADIUS;
  localparam int SQ_Y_HI = `MC_CENTER_Y + `MC_RADIUS;

  // Squared distance from the board centre
  function automatic dist_sq_t center_dist_sq(coord_t x, coord_t y);
    logic signed [`MC_COORD_W:0] dx;
    logic signed [`MC_COORD_W:0] dy;
    dist_sq_t                    dx_sq;
    dist_sq_t                    dy_sq;
    dx = $signed({1'b0, x}) - $signed((`MC_COORD_W+1)'(`MC_CENTER_X));
    dy = $signed({1'b0, y}) - $signed((`MC_COORD_W+1)'(`MC_CENTER_Y));
    dx_sq = dx * dx;  // Sign extended to full width before the multiply
    dy_sq = dy * dy;
    return dx_sq + dy_sq;
  endfunction

  function automatic logic inside_square(coord_t x, coord_t y);
    return (x > SQ_X_LO) && (x < SQ_X_HI) && (y > SQ_Y_LO) && (y < SQ_Y_HI);
  endfunction

endpackage

`default_nettype wire

//--- vga_timing.sv
// **********************************************************
// VGA raster counters with active-low sync pulses
// and the active-area flag
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module vga_timing (
  input  logic                  clk,
  input  logic                  rst_n,
  output mc_pi_pkg::pixel_pos_t pos,
  output logic                  hsync,
  output logic                  vsync
);
  import mc_pi_pkg::*;

  localparam int H_SYNC_START = `MC_H_ACTIVE + `MC_H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `MC_H_SYNC;
  localparam int V_SYNC_START = `MC_V_ACTIVE + `MC_V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `MC_V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;

  assign h_last = (h_cnt == coord_t'(`MC_H_TOTAL - 1));
  assign v_last = (v_cnt == coord_t'(`MC_V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // Next line, or back to the top
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign pos.x      = h_cnt;
  assign pos.y      = v_cnt;
  assign pos.active = (h_cnt < `MC_H_ACTIVE) && (v_cnt < `MC_V_ACTIVE);

  // Sync low inside the pulse window
  assign hsync = !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END));
  assign vsync = !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));

  a_counters_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (h_cnt < `MC_H_TOTAL) && (v_cnt < `MC_V_TOTAL)
  );

endmodule

`default_nettype wire

//--- point_sampler.sv
// **********************************************************
// 20-bit LFSR point source, one point per step under run
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module point_sampler (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              run,
  output mc_pi_pkg::point_t sample,
  output logic              sample_valid
);
  import mc_pi_pkg::*;

  logic [`MC_LFSR_W-1:0] lfsr;
  logic                  feedback;

  // Taps 19, 18, 17 and 15
  assign feedback = lfsr[19] ^ lfsr[18] ^ lfsr[17] ^ lfsr[15];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lfsr         <= `MC_LFSR_SEED;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= run;  // Pulses along with each step
      if (run) begin
        lfsr <= {lfsr[`MC_LFSR_W-2:0], feedback};
      end
    end
  end

  // Low half is x, high half is y
  assign sample = '{
    x: lfsr[`MC_COORD_W-1:0],
    y: lfsr[`MC_LFSR_W-1 -: `MC_COORD_W]
  };

endmodule

`default_nettype wire

//--- hit_classifier.sv
// **********************************************************
// Registered circle and square membership test per point
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module hit_classifier (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sample_valid,
  input  mc_pi_pkg::point_t sample,
  output mc_pi_pkg::hit_t   hit,
  output logic              hit_valid
);
  import mc_pi_pkg::*;

  localparam dist_sq_t RADIUS_SQ = dist_sq_t'(`MC_RADIUS * `MC_RADIUS);

  dist_sq_t dist_sq;
  logic     in_circle;
  logic     in_square;

  assign dist_sq   = center_dist_sq(sample.x, sample.y);
  assign in_circle = (dist_sq < RADIUS_SQ);  // Strictly inside the circle
  assign in_square = inside_square(sample.x, sample.y);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_valid <= 1'b0;
    end else begin
      hit_valid <= sample_valid;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      hit.pt        <= sample;
      hit.in_circle <= in_circle;
      hit.in_square <= in_square;
    end
  end

  // Circle is inscribed in the square
  a_circle_in_square: assert property (
    @(posedge clk) disable iff (!rst_n)
    hit_valid |-> (!hit.in_circle || hit.in_square)
  );

endmodule

`default_nettype wire

//--- hit_tally.sv
// **********************************************************
// Circle and square hit counters
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module hit_tally (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              hit_valid,
  input  mc_pi_pkg::hit_t   hit,
  output mc_pi_pkg::tally_t tally
);
  import mc_pi_pkg::*;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tally.circle_hits <= '0;
      tally.square_hits <= '0;
    end else if (hit_valid) begin
      // Both wrap at the counter width
      if (hit.in_circle) begin
        tally.circle_hits <= tally.circle_hits + 1'b1;
      end
      if (hit.in_square) begin
        tally.square_hits <= tally.square_hits + 1'b1;
      end
    end
  end

  // Every circle hit was also counted as a square hit
  a_circle_le_square: assert property (
    @(posedge clk) disable iff (!rst_n)
    tally.circle_hits <= tally.square_hits
  );

endmodule

`default_nettype wire

//--- board_renderer.sv
// **********************************************************
// Board drawing: circle ring, square outline, point marker,
// and the registered VGA pins
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module board_renderer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  hsync,
  input  logic                  vsync,
  input  logic                  hit_valid,
  input  mc_pi_pkg::pixel_pos_t pos,
  input  mc_pi_pkg::hit_t       hit,
  output mc_pi_pkg::vga_out_t   vga
);
  import mc_pi_pkg::*;

  localparam dist_sq_t RING_IN  = dist_sq_t'((`MC_RADIUS - 1) * (`MC_RADIUS - 1));
  localparam dist_sq_t RING_OUT = dist_sq_t'(`MC_RADIUS * `MC_RADIUS);
  localparam logic [`MC_COORD_W:0] HALF = (`MC_COORD_W+1)'(`MC_MARK_HALF);

  point_t   mark;
  logic     mark_on;
  dist_sq_t pix_dist;
  logic     x_inner;
  logic     y_inner;
  logic     on_ring;
  logic     on_outline;
  logic     near_x;
  logic     near_y;
  logic     on_marker;

  // Latest in-square point
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mark_on <= 1'b0;
    end else if (hit_valid && hit.in_square) begin
      mark_on <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_valid && hit.in_square) begin
      mark <= hit.pt;
    end
  end

  assign pix_dist = center_dist_sq(pos.x, pos.y);
  assign on_ring  = (pix_dist >= RING_IN) && (pix_dist <= RING_OUT);

  assign x_inner    = (pos.x > SQ_X_LO) && (pos.x < SQ_X_HI);
  assign y_inner    = (pos.y > SQ_Y_LO) && (pos.y < SQ_Y_HI);
  assign on_outline = (((pos.x == SQ_X_LO) || (pos.x == SQ_X_HI)) && y_inner) ||
                      (((pos.y == SQ_Y_LO) || (pos.y == SQ_Y_HI)) && x_inner);

  // One extra bit so the +HALF sums cannot wrap
  assign near_x = ({1'b0, pos.x} + HALF > {1'b0, mark.x}) &&
                  ({1'b0, pos.x} < {1'b0, mark.x} + HALF);
  assign near_y = ({1'b0, pos.y} + HALF > {1'b0, mark.y}) &&
                  ({1'b0, pos.y} < {1'b0, mark.y} + HALF);

  // Clipped to the square interior
  assign on_marker = mark_on && near_x && near_y && inside_square(pos.x, pos.y);

  // Sync and colour leave on the same edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.red   <= 2'b00;
      vga.green <= 2'b00;
      vga.blue  <= 2'b00;
    end else begin
      vga.hsync <= hsync;
      vga.vsync <= vsync;
      vga.red   <= {2{pos.active && (on_ring || on_outline)}};
      vga.green <= {2{pos.active && on_marker}};
      vga.blue  <= 2'b00;
    end
  end

  // Only classified in-square points reach the marker
  a_marker_in_square: assert property (
    @(posedge clk) disable iff (!rst_n)
    mark_on |-> inside_square(mark.x, mark.y)
  );

endmodule

`default_nettype wire

//--- mc_pi_top.sv
// **********************************************************
// Top level: point sampler chain and VGA raster chain
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module mc_pi_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  output mc_pi_pkg::vga_out_t vga,
  output mc_pi_pkg::tally_t   tally
);

  mc_pi_pkg::pixel_pos_t pos;
  logic                  hsync;
  logic                  vsync;
  mc_pi_pkg::point_t     sample;
  logic                  sample_valid;
  mc_pi_pkg::hit_t       hit;
  logic                  hit_valid;

  // Raster side
  vga_timing u_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos),
    .hsync (hsync),
    .vsync (vsync)
  );

  // Sample side
  point_sampler u_sampler (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  hit_classifier u_classifier (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample       (sample),
    .hit          (hit),
    .hit_valid    (hit_valid)
  );

  hit_tally u_tally (
    .clk       (clk),
    .rst_n     (rst_n),
    .hit_valid (hit_valid),
    .hit       (hit),
    .tally     (tally)
  );

  board_renderer u_renderer (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsync     (hsync),
    .vsync     (vsync),
    .hit_valid (hit_valid),
    .pos       (pos),
    .hit       (hit),
    .vga       (vga)
  );

endmodule

`default_nettype wire

//--- tb_mc_pi.sv
// **********************************************************
// Testbench for mc_pi_top: LFSR and raster reference model,
// random run stimulus, and assertion checks
// **********************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mc_pi_params.svh"

module tb_mc_pi;
  import mc_pi_pkg::*;

  localparam int CYCLE_LIMIT  = 1300000;  // About three frames

  logic     clk;
  logic     rst_n;
  logic     run;
  vga_out_t vga;
  tally_t   tally;

  // Reference model state
  logic [`MC_LFSR_W-1:0]  ref_lfsr;
  logic [`MC_LFSR_W-1:0]  pt_d1;
  logic [`MC_LFSR_W-1:0]  pt_d2;
  logic                   run_d1;
  logic                   run_d2;
  logic [`MC_COUNT_W-1:0] ref_circle;
  logic [`MC_COUNT_W-1:0] ref_square;
  logic [`MC_LFSR_W-1:0]  ref_mark;
  logic                   ref_mark_on;
  int                     h_ref;
  int                     v_ref;
  int                     shown_x;  // Pixel currently on the pins
  int                     shown_y;
  logic [`MC_LFSR_W-1:0]  shown_mark;
  logic                   shown_mark_on;
  logic                   shown_valid;
  logic                   shown_active;
  logic                   exp_hsync;
  logic                   exp_vsync;
  logic [1:0]             exp_red;
  logic [1:0]             exp_green;
  int                     cycles;
  int                     burst;

  mc_pi_top dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .vga   (vga),
    .tally (tally)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [`MC_LFSR_W-1:0] next_lfsr(input logic [`MC_LFSR_W-1:0] v);
    return {v[18:0], v[19] ^ v[18] ^ v[17] ^ v[15]};
  endfunction

  function automatic int dist_from_center(input int x, input int y);
    int dx;
    int dy;
    dx = x - `MC_CENTER_X;
    dy = y - `MC_CENTER_Y;
    return dx * dx + dy * dy;
  endfunction

  function automatic logic in_square_interior(input int x, input int y);
    return (x > 160) && (x < 480) && (y > 80) && (y < 400);
  endfunction

  // Circle ring plus square outline
  function automatic logic board_pixel(input int x, input int y);
    int d;
    logic ring;
    logic outline;
    d = dist_from_center(x, y);
    ring = (d >= 159 * 159) && (d <= 160 * 160);
    outline = ((x == 160 || x == 480) && y >= 81 && y <= 399) ||
              ((y == 80 || y == 400) && x >= 161 && x <= 479);
    return ring || outline;
  endfunction

  function automatic logic marker_pixel(input int x, input int y,
                                        input logic [`MC_LFSR_W-1:0] mark, input logic on);
    int mx;
    int my;
    mx = int'(mark[9:0]);
    my = int'(mark[19:10]);
    return on && (x - mx < 10) && (mx - x < 10) && (y - my < 10) && (my - y < 10) &&
           in_square_interior(x, y);
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s: expected %0h, actual %0h", test_name, expected, actual);
    abort_run();
  endtask

  // Model steps on the same edges as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      ref_lfsr    <= `MC_LFSR_SEED;
      run_d1      <= 1'b0;
      run_d2      <= 1'b0;
      ref_circle  <= '0;
      ref_square  <= '0;
      ref_mark_on <= 1'b0;
      h_ref       <= 0;
      v_ref       <= 0;
      shown_valid <= 1'b0;
    end else begin
      if (run) begin
        ref_lfsr <= next_lfsr(ref_lfsr);
      end
      run_d1 <= run;
      pt_d1  <= next_lfsr(ref_lfsr);
      run_d2 <= run_d1;
      pt_d2  <= pt_d1;
      if (run_d2) begin  // Point reaches the counters two edges after its run edge
        if (dist_from_center(int'(pt_d2[9:0]), int'(pt_d2[19:10])) < 160 * 160) begin
          ref_circle <= ref_circle + 1;
        end
        if (in_square_interior(int'(pt_d2[9:0]), int'(pt_d2[19:10]))) begin
          ref_square  <= ref_square + 1;
          ref_mark    <= pt_d2;
          ref_mark_on <= 1'b1;
        end
      end
      shown_x       <= h_ref;
      shown_y       <= v_ref;
      shown_mark    <= ref_mark;
      shown_mark_on <= ref_mark_on;
      shown_valid   <= 1'b1;
      if (h_ref == `MC_H_TOTAL - 1) begin
        h_ref <= 0;
        v_ref <= (v_ref == `MC_V_TOTAL - 1) ? 0 : v_ref + 1;
      end else begin
        h_ref <= h_ref + 1;
      end
    end
  end

  // Sync pulses on columns 656..751 and lines 490..491
  assign shown_active = (shown_x < `MC_H_ACTIVE) && (shown_y < `MC_V_ACTIVE);
  assign exp_hsync = !((shown_x >= 656) && (shown_x <= 751));
  assign exp_vsync = !((shown_y >= 490) && (shown_y <= 491));
  assign exp_red   = {2{shown_active && board_pixel(shown_x, shown_y)}};
  assign exp_green = {2{shown_active &&
                        marker_pixel(shown_x, shown_y, shown_mark, shown_mark_on)}};

  a_hsync: assert property (@(posedge clk) !shown_valid || vga.hsync == exp_hsync)
    else report_mismatch("hsync", $sampled(exp_hsync), $sampled(vga.hsync));
  a_vsync: assert property (@(posedge clk) !shown_valid || vga.vsync == exp_vsync)
    else report_mismatch("vsync", $sampled(exp_vsync), $sampled(vga.vsync));
  a_blanking: assert property (@(posedge clk)
    !shown_valid || shown_active || (vga.red == 0 && vga.green == 0 && vga.blue == 0))
    else report_mismatch("blanking", 0, $sampled({vga.red, vga.green, vga.blue}));
  a_blue: assert property (@(posedge clk) !shown_valid || vga.blue == 2'b00)
    else report_mismatch("blue", 0, $sampled(vga.blue));
  a_red: assert property (@(posedge clk) !shown_valid || vga.red == exp_red)
    else report_mismatch("board red", $sampled(exp_red), $sampled(vga.red));
  a_green: assert property (@(posedge clk) !shown_valid || vga.green == exp_green)
    else report_mismatch("marker green", $sampled(exp_green), $sampled(vga.green));

  a_tally: assert property (@(posedge clk) disable iff (!rst_n)
    tally == {ref_circle, ref_square})
    else report_mismatch("tally", $sampled({ref_circle, ref_square}), $sampled(tally));
  a_reset_tally: assert property (@(posedge clk) $rose(rst_n) |-> tally == '0)
    else report_mismatch("tally after reset", 0, $sampled(tally));
  a_hold: assert property (@(posedge clk) disable iff (!rst_n) !run_d2 |=> $stable(tally))
    else begin
      $display("Tally changed although run was low two cycles earlier");
      abort_run();
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  initial begin
    cycles = 0;
    burst  = 0;
    rst_n  = 1'b0;
    run    = 1'b0;
    void'($urandom(39983));
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Random bursts of run high and low
    for (int i = 0; i < 2000; i++) begin
      if (burst == 0) begin
        run   = $urandom % 2;
        burst = 1 + $urandom % 16;
      end
      burst = burst - 1;
      @(negedge clk);
    end
    run = 1'b0;
    // Two full frames with the board and marker frozen
    repeat (3) @(negedge vga.vsync);
    @(negedge clk);
    if (ref_square == 0 || ref_circle == 0) begin
      $display("Random phase produced no circle or square hit to check");
      abort_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
mc_pi_pkg.sv
vga_timing.sv
point_sampler.sv
hit_classifier.sv
hit_tally.sv
board_renderer.sv
mc_pi_top.sv
tb_mc_pi.sv

//--- Makefile
# Verilator simulation of the Monte Carlo pi board

TOP := tb_mc_pi

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
